//--- hdl/display_pkg.sv
/* Shared display timing, framebuffer sizes and vector types for the scan-out path.
   Modules import it in their body and use scoped names in port lists. */

package display_pkg;

	// Horizontal timing in clocks
	localparam int h_active = 16;
	localparam int h_front  = 2;
	localparam int h_sync   = 4;
	localparam int h_back   = 2;
	localparam int h_total  = h_active + h_front + h_sync + h_back;

	// Vertical timing in lines
	localparam int v_active = 8;
	localparam int v_front  = 1;
	localparam int v_sync   = 2;
	localparam int v_back   = 1;
	localparam int v_total  = v_active + v_front + v_sync + v_back;

	// Four RGB332 pixels per word, whole frame
	localparam int fb_words = h_active * v_active / 4;

	// Prefetch FIFO, power of two
	localparam int fifo_depth = 8;
	localparam int fifo_ptr_w = $clog2(fifo_depth);

	// AXI read response code
	localparam logic [1:0] axi_resp_okay = 2'b00;

	// Bus and RAM data word
	typedef logic [31:0] word_t;

	// AXI byte address
	typedef logic [31:0] axi_addr_t;

	// Framebuffer word index
	typedef logic [4:0] fb_addr_t;

	// Scan counters
	typedef logic [4:0] hcount_t;
	typedef logic [3:0] vcount_t;

	// Stored pixel, red 7:5, green 4:2, blue 1:0
	typedef logic [7:0] pixel_t;

	// One output colour channel
	typedef logic [7:0] color_t;

endpackage

//--- hdl/display_top.sv
/* Display path top level. Framebuffer RAM feeding the scan-out pipeline of
   timing, fetch and unpack stages that drives the VGA-style output pins. */
`timescale 1ns/1ps

module display_top (
	input  logic                  clk,
	input  logic                  arst_n,
	// Loader port into the framebuffer
	input  logic                  loader_we,
	input  display_pkg::fb_addr_t loader_addr,
	input  display_pkg::word_t    loader_data,
	// VGA output
	output display_pkg::color_t   vga_r,
	output display_pkg::color_t   vga_g,
	output display_pkg::color_t   vga_b,
	output logic                  vga_hs,
	output logic                  vga_vs,
	output logic                  vga_blank_n,
	output logic                  underrun
);
	import display_pkg::*;

	// AXI4-Lite read channel, fetch to RAM
	logic       arvalid;
	logic       arready;
	axi_addr_t  araddr;
	logic       rvalid;
	logic       rready;
	word_t      rdata;
	logic [1:0] rresp;

	// Raster timing
	hcount_t hcount;
	logic    active;
	logic    hs;
	logic    vs;
	logic    frame_start;

	// Word stream, fetch to unpack
	logic  word_valid;
	word_t word_data;
	logic  word_take;

	fb_ram fb_ram_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.loader_we   (loader_we),
		.loader_addr (loader_addr),
		.loader_data (loader_data),
		.arvalid     (arvalid),
		.arready     (arready),
		.araddr      (araddr),
		.rvalid      (rvalid),
		.rready      (rready),
		.rdata       (rdata),
		.rresp       (rresp)
	);

	scan_timing scan_timing_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.hcount      (hcount),
		.active      (active),
		.hs          (hs),
		.vs          (vs),
		.frame_start (frame_start)
	);

	fb_fetch fb_fetch_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.frame_start (frame_start),
		.arvalid     (arvalid),
		.arready     (arready),
		.araddr      (araddr),
		.rvalid      (rvalid),
		.rready      (rready),
		.rdata       (rdata),
		.rresp       (rresp),
		.word_valid  (word_valid),
		.word_data   (word_data),
		.word_take   (word_take)
	);

	pixel_unpack pixel_unpack_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.active      (active),
		.hs          (hs),
		.vs          (vs),
		.hcount      (hcount),
		.word_valid  (word_valid),
		.word_data   (word_data),
		.word_take   (word_take),
		.vga_r       (vga_r),
		.vga_g       (vga_g),
		.vga_b       (vga_b),
		.vga_hs      (vga_hs),
		.vga_vs      (vga_vs),
		.vga_blank_n (vga_blank_n),
		.underrun    (underrun)
	);

endmodule

//--- hdl/fb_fetch.sv
/* Framebuffer prefetch. Reads the frame word by word as an AXI4-Lite master,
   one read in flight, and queues the words in a FIFO for the unpack stage. */
`timescale 1ns/1ps

module fb_fetch (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   frame_start,
	// AXI4-Lite read master
	output logic                   arvalid,
	input  logic                   arready,
	output display_pkg::axi_addr_t araddr,
	input  logic                   rvalid,
	output logic                   rready,
	input  display_pkg::word_t     rdata,
	input  logic [1:0]             rresp,
	// FIFO head towards unpack
	output logic                   word_valid,
	output display_pkg::word_t     word_data,
	input  logic                   word_take
);
	import display_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_addr,
		st_data
	} fetch_state_t;

	fetch_state_t          state;
	fetch_state_t          state_nxt;
	fb_addr_t              next_idx;
	fb_addr_t              req_idx;
	logic                  done;
	logic                  discard;
	logic                  ar_xfer;
	logic                  r_xfer;
	logic                  more;
	logic                  push;
	logic                  pop;
	word_t                 fifo_mem [fifo_depth];
	logic [fifo_ptr_w-1:0] wr_ptr;
	logic [fifo_ptr_w-1:0] rd_ptr;
	logic [fifo_ptr_w:0]   count;

	assign arvalid = state == st_addr;
	assign ar_xfer = arvalid && arready;

	// Count MSB set means full; stale data drains regardless
	assign rready = (state == st_data) && (discard || !count[fifo_ptr_w]);
	assign r_xfer = rvalid && rready;

	// Another request is due unless the frame is complete
	assign more = frame_start || !done;

	// Index for the next request, restarted by frame start
	assign req_idx = frame_start ? '0 : next_idx;

	// Flush wins over both FIFO ports
	assign push = r_xfer && !discard && !frame_start;
	assign pop  = word_take && word_valid && !frame_start;

	// Back to back reads give one word every two clocks
	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: if (more) state_nxt = st_addr;
			st_addr: if (ar_xfer) state_nxt = st_data;
			st_data: if (r_xfer) state_nxt = more ? st_addr : st_idle;
			default: state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= st_idle;
			next_idx <= '0;
			done     <= 1'b0;
			discard  <= 1'b0;
		end else begin
			state <= state_nxt;
			if (frame_start) begin
				next_idx <= '0;
				done     <= 1'b0;
				// A read still in flight belongs to the old frame
				discard  <= (state == st_addr) || (state == st_data && !r_xfer);
			end else begin
				if (ar_xfer && !discard) begin
					if (next_idx == fb_addr_t'(fb_words - 1)) begin
						done <= 1'b1;
					end else begin
						next_idx <= next_idx + 1'b1;
					end
				end
				if (r_xfer) begin
					discard <= 1'b0;
				end
			end
		end
	end

	// Address held stable from entry into the address state until accepted
	always_ff @(posedge clk) begin
		if (state_nxt == st_addr && state != st_addr) begin
			araddr <= axi_addr_t'({req_idx, 2'b00});
		end
	end

	// Error responses show as black
	always_ff @(posedge clk) begin
		if (push) begin
			fifo_mem[wr_ptr] <= (rresp == axi_resp_okay) ? rdata : '0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (frame_start) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	assign word_valid = count != '0;
	assign word_data  = fifo_mem[rd_ptr];

endmodule

//--- hdl/fb_ram.sv
/* On-chip framebuffer RAM. The loader port writes words at any time and
   the scan-out fetch stage reads them through an AXI4-Lite read slave. */
`timescale 1ns/1ps

module fb_ram (
	input  logic                   clk,
	input  logic                   arst_n,
	// Loader port, no handshake
	input  logic                   loader_we,
	input  display_pkg::fb_addr_t  loader_addr,
	input  display_pkg::word_t     loader_data,
	// AXI4-Lite read address channel
	input  logic                   arvalid,
	output logic                   arready,
	input  display_pkg::axi_addr_t araddr,
	// AXI4-Lite read data channel
	output logic                   rvalid,
	input  logic                   rready,
	output display_pkg::word_t     rdata,
	output logic [1:0]             rresp
);
	import display_pkg::*;

	word_t    mem [fb_words];
	fb_addr_t rd_idx;
	logic     ar_xfer;

	// Byte address to word index
	assign rd_idx = araddr[6:2];

	// Accept a new address only with no response pending
	assign arready = !rvalid;
	assign ar_xfer = arvalid && arready;

	// Internal RAM never faults
	assign rresp = axi_resp_okay;

	// Loader write port
	always_ff @(posedge clk) begin
		if (loader_we) begin
			mem[loader_addr] <= loader_data;
		end
	end

	// Read port, old word on a same-cycle loader write
	always_ff @(posedge clk) begin
		if (ar_xfer) begin
			rdata <= mem[rd_idx];
		end
	end

	// Pending response, held until the master takes it
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rvalid <= 1'b0;
		end else if (ar_xfer) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

endmodule

//--- hdl/pixel_unpack.sv
/* Pixel unpack stage. Picks RGB332 bytes out of fetched words, expands them
   to 8-bit channels and lines up colour, sync and blank on the output pins. */
`timescale 1ns/1ps

module pixel_unpack (
	input  logic                 clk,
	input  logic                 arst_n,
	// Scan timing
	input  logic                 active,
	input  logic                 hs,
	input  logic                 vs,
	input  display_pkg::hcount_t hcount,
	// FIFO head from fetch
	input  logic                 word_valid,
	input  display_pkg::word_t   word_data,
	output logic                 word_take,
	// Display output
	output display_pkg::color_t  vga_r,
	output display_pkg::color_t  vga_g,
	output display_pkg::color_t  vga_b,
	output logic                 vga_hs,
	output logic                 vga_vs,
	output logic                 vga_blank_n,
	output logic                 underrun
);
	import display_pkg::*;

	pixel_t pix_sel;
	logic   show;
	logic   byte_last;
	pixel_t pix_q;
	logic   blank_n_q;
	logic   hs_q;
	logic   vs_q;
	logic   armed;

	// Repeat a 3-bit field from the top down
	function automatic color_t expand3(input logic [2:0] f);
		return {f, f, f[2:1]};
	endfunction

	// Pixel 0 in the low byte
	assign pix_sel   = word_data[{hcount[1:0], 3'b000} +: 8];
	assign show      = active && word_valid;
	assign byte_last = hcount[1:0] == 2'd3;

	// Word consumed with its fourth pixel
	assign word_take = show && byte_last;

	// Stage one, byte select; a missing word shows black
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pix_q     <= '0;
			blank_n_q <= 1'b0;
			hs_q      <= 1'b1;
			vs_q      <= 1'b1;
		end else begin
			pix_q     <= show ? pix_sel : '0;
			blank_n_q <= active;
			hs_q      <= hs;
			vs_q      <= vs;
		end
	end

	// Stage two, colour expansion to the pins
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vga_r       <= '0;
			vga_g       <= '0;
			vga_b       <= '0;
			vga_hs      <= 1'b1;
			vga_vs      <= 1'b1;
			vga_blank_n <= 1'b0;
		end else begin
			vga_r       <= expand3(pix_q[7:5]);
			vga_g       <= expand3(pix_q[4:2]);
			vga_b       <= {4{pix_q[1:0]}};
			vga_hs      <= hs_q;
			vga_vs      <= vs_q;
			vga_blank_n <= blank_n_q;
		end
	end

	// Fetch lines up with the raster only after its first frame start,
	// which falls inside vertical sync, so underruns count from there
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			armed    <= 1'b0;
			underrun <= 1'b0;
		end else begin
			armed    <= armed || !vs;
			underrun <= underrun || (armed && active && !word_valid);
		end
	end

endmodule

//--- hdl/scan_timing.sv
/* Raster timing generator. Free-running pixel and line counters decoded into
   active flag, active-low syncs and a frame start pulse for the fetch stage. */
`timescale 1ns/1ps

module scan_timing (
	input  logic                 clk,
	input  logic                 arst_n,
	output display_pkg::hcount_t hcount,
	output logic                 active,
	output logic                 hs,
	output logic                 vs,
	output logic                 frame_start
);
	import display_pkg::*;

	hcount_t h_cnt;
	vcount_t v_cnt;
	logic    h_last;
	logic    v_last;
	logic    h_act;
	logic    v_act;
	logic    hs_pulse;
	logic    vs_pulse;
	logic    vs_enter;

	// End of line and end of frame
	assign h_last = h_cnt == hcount_t'(h_total - 1);
	assign v_last = v_cnt == vcount_t'(v_total - 1);

	// Pixel counter wraps every line, line counter every frame
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			if (h_last) begin
				h_cnt <= '0;
				if (v_last) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 1'b1;
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// Visible region sits at the start of each line and frame
	assign h_act = h_cnt < hcount_t'(h_active);
	assign v_act = v_cnt < vcount_t'(v_active);

	// Sync pulses follow the front porch
	assign hs_pulse = (h_cnt >= hcount_t'(h_active + h_front)) &&
		(h_cnt < hcount_t'(h_active + h_front + h_sync));
	assign vs_pulse = (v_cnt >= vcount_t'(v_active + v_front)) &&
		(v_cnt < vcount_t'(v_active + v_front + v_sync));

	// First clock of the vertical sync region
	assign vs_enter = (v_cnt == vcount_t'(v_active + v_front)) && (h_cnt == '0);

	// Registered outputs, one clock behind the counters
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hcount      <= '0;
			active      <= 1'b0;
			hs          <= 1'b1;
			vs          <= 1'b1;
			frame_start <= 1'b0;
		end else begin
			hcount      <= h_cnt;
			active      <= h_act && v_act;
			hs          <= !hs_pulse;
			vs          <= !vs_pulse;
			frame_start <= vs_enter;
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the display testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module display_tb -o display_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/display_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "All checks passed"; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1

//--- tb/display_checks.sv
/* Reference model and output checks for the display testbench. Mirrors the
   loader writes into its own image and checks syncs, pixels, blanking and underrun. */
`timescale 1ns/1ps

module display_checks (
	input  logic                  clk,
	input  logic                  arst_n,
	// Loader port, observed like the RAM sees it
	input  logic                  loader_we,
	input  display_pkg::fb_addr_t loader_addr,
	input  display_pkg::word_t    loader_data,
	// DUT outputs
	input  display_pkg::color_t   vga_r,
	input  display_pkg::color_t   vga_g,
	input  display_pkg::color_t   vga_b,
	input  logic                  vga_hs,
	input  logic                  vga_vs,
	input  logic                  vga_blank_n,
	input  logic                  underrun,
	// Results towards the testbench top
	output int                    sync_errors,
	output int                    pixel_errors,
	output int                    state_errors,
	output int                    frames_checked
);
	import display_pkg::*;

	// Counter to output pin delay
	localparam int latency   = 3;
	localparam int pix_total = h_active * v_active;
	localparam int frame_len = v_total * h_total;

	word_t  image [fb_words];
	word_t  frame_img [fb_words];
	bit     reset_seen;
	int     cyc;
	// Sync edge tracking
	bit     hs_prev;
	bit     vs_prev;
	bit     hs_fall_seen;
	bit     vs_fall_seen;
	int     hs_low;
	int     vs_low;
	int     hs_period;
	int     vs_period;
	// Pixel tracking
	bit     started;
	bit     vs_last;
	int     pix;
	word_t  cur_word;
	pixel_t cur_pix;

	// 3-bit field repeated from the top until all 8 bits are filled
	function automatic color_t expand_field(input logic [2:0] f);
		logic [23:0] rep;
		rep = {8{f}};
		return rep[23:16];
	endfunction

	// 2-bit blue repeated four times
	function automatic color_t repeat_blue(input logic [1:0] f);
		return color_t'(f) * 8'h55;
	endfunction

	task automatic expect_sync(input string name, input int expected, input int actual);
		assert (actual == expected) else begin
			sync_errors = sync_errors + 1;
			$display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic compare_colour(input string name, input color_t expected,
		input color_t actual);
		assert (actual == expected) else begin
			pixel_errors = pixel_errors + 1;
			$display("[FAIL] %s pixel %0d expected 0x%02h actual 0x%02h",
				name, pix, expected, actual);
		end
	endtask

	task automatic verify_state(input string name, input int expected, input int actual);
		assert (actual == expected) else begin
			state_errors = state_errors + 1;
			$display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
		end
	endtask

	// Clocks since reset release, for the state being sampled
	always @(posedge clk) begin
		reset_seen <= reset_seen || !arst_n;
		cyc        <= arst_n ? cyc + 1 : 0;
	end

	// Own copy of the RAM image
	always @(posedge clk) begin
		if (loader_we) begin
			image[loader_addr] <= loader_data;
		end
	end

	// Reset values, blanked colour and underrun
	always @(posedge clk) begin
		if (reset_seen && (!arst_n || cyc == 0)) begin
			verify_state("reset hs,vs,blank_n,underrun", int'(4'b1100),
				int'({vga_hs, vga_vs, vga_blank_n, underrun}));
			verify_state("reset colour", 0, int'({vga_r, vga_g, vga_b}));
		end
		if (reset_seen && arst_n) begin
			if (!vga_blank_n) begin
				verify_state("blanked colour", 0, int'({vga_r, vga_g, vga_b}));
			end
			verify_state("underrun", 0, int'(underrun));
		end
	end

	// Sync pulse widths, periods and the first edges after reset
	always @(posedge clk) begin
		if (!arst_n) begin
			hs_prev      = 1'b1;
			vs_prev      = 1'b1;
			hs_fall_seen = 1'b0;
			vs_fall_seen = 1'b0;
			hs_low       = 0;
			vs_low       = 0;
			hs_period    = 0;
			vs_period    = 0;
		end else if (reset_seen) begin
			if (hs_prev && !vga_hs) begin
				if (hs_fall_seen) begin
					expect_sync("hsync period", h_total, hs_period);
				end else begin
					expect_sync("first hsync fall", h_active + h_front + latency, cyc);
				end
				hs_fall_seen = 1'b1;
				hs_period    = 0;
				hs_low       = 0;
			end
			if (!hs_prev && vga_hs) begin
				expect_sync("hsync width", h_sync, hs_low);
			end
			if (vs_prev && !vga_vs) begin
				if (vs_fall_seen) begin
					expect_sync("vsync period", frame_len, vs_period);
				end else begin
					expect_sync("first vsync fall",
						(v_active + v_front) * h_total + latency, cyc);
				end
				vs_fall_seen = 1'b1;
				vs_period    = 0;
				vs_low       = 0;
			end
			if (!vs_prev && vga_vs) begin
				expect_sync("vsync width", v_sync * h_total, vs_low);
			end
			hs_period = hs_period + 1;
			vs_period = vs_period + 1;
			hs_low    = hs_low + (vga_hs ? 0 : 1);
			vs_low    = vs_low + (vga_vs ? 0 : 1);
			hs_prev   = vga_hs;
			vs_prev   = vga_vs;
		end
	end

	// Pixel data against the image taken when vertical sync starts
	always @(posedge clk) begin
		if (!arst_n) begin
			started = 1'b0;
			vs_last = 1'b1;
			pix     = 0;
		end else if (reset_seen) begin
			if (vs_last && !vga_vs) begin
				frame_img = image;
			end
			if (!vs_last && vga_vs) begin
				// Frame closes here, count its visible pixels
				if (started) begin
					assert (pix == pix_total) else begin
						pixel_errors = pixel_errors + 1;
						$display("[FAIL] visible pixels per frame expected %0d actual %0d",
							pix_total, pix);
					end
					frames_checked = frames_checked + 1;
				end
				started = 1'b1;
				pix     = 0;
			end
			if (started && vga_blank_n) begin
				if (pix < pix_total) begin
					cur_word = frame_img[fb_addr_t'(pix / 4)] >> (8 * (pix % 4));
					cur_pix  = cur_word[7:0];
					compare_colour("red", expand_field(cur_pix[7:5]), vga_r);
					compare_colour("green", expand_field(cur_pix[4:2]), vga_g);
					compare_colour("blue", repeat_blue(cur_pix[1:0]), vga_b);
				end
				pix = pix + 1;
			end
			vs_last = vga_vs;
		end
	end

endmodule

//--- tb/display_tb.sv
/* Testbench for the display path. Loads random images over the loader port,
   runs the scan-out for four checked frames and reports the checker's counts. */
`timescale 1ns/1ps

module display_tb;
	import display_pkg::*;

	localparam int frame_len  = v_total * h_total;
	localparam int frames_run = 4;

	logic     clk;
	logic     arst_n;
	logic     loader_we;
	fb_addr_t loader_addr;
	word_t    loader_data;
	color_t   vga_r;
	color_t   vga_g;
	color_t   vga_b;
	logic     vga_hs;
	logic     vga_vs;
	logic     vga_blank_n;
	logic     underrun;
	int       seed;
	int       sync_errors;
	int       pixel_errors;
	int       state_errors;
	int       frames_checked;
	int       other_errors;
	bit       timed_out;

	// 100 ns clock
	always #50 clk = ~clk;

	display_top dut_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.loader_we   (loader_we),
		.loader_addr (loader_addr),
		.loader_data (loader_data),
		.vga_r       (vga_r),
		.vga_g       (vga_g),
		.vga_b       (vga_b),
		.vga_hs      (vga_hs),
		.vga_vs      (vga_vs),
		.vga_blank_n (vga_blank_n),
		.underrun    (underrun)
	);

	display_checks checks_i (
		.clk            (clk),
		.arst_n         (arst_n),
		.loader_we      (loader_we),
		.loader_addr    (loader_addr),
		.loader_data    (loader_data),
		.vga_r          (vga_r),
		.vga_g          (vga_g),
		.vga_b          (vga_b),
		.vga_hs         (vga_hs),
		.vga_vs         (vga_vs),
		.vga_blank_n    (vga_blank_n),
		.underrun       (underrun),
		.sync_errors    (sync_errors),
		.pixel_errors   (pixel_errors),
		.state_errors   (state_errors),
		.frames_checked (frames_checked)
	);

	// One random word per clock into every framebuffer word
	task automatic load_image();
		int i;
		for (i = 0; i < fb_words; i++) begin
			@(negedge clk);
			loader_we   = 1'b1;
			loader_addr = fb_addr_t'(i);
			loader_data = $random(seed);
		end
		@(negedge clk);
		loader_we = 1'b0;
	endtask

	task automatic print_counts();
		$display("Errors: sync %0d, pixel %0d, state %0d, other %0d",
			sync_errors, pixel_errors, state_errors, other_errors);
	endtask

	function automatic logic probe(input bit use_blank);
		return use_blank ? vga_blank_n : vga_vs;
	endfunction

	// Wait for vga_vs or vga_blank_n to change to a level, sampled mid-cycle
	// Skipped once an earlier wait has timed out
	task automatic wait_change(input bit use_blank, input logic level, input int limit,
		input string what);
		logic last;
		logic hit;
		int   n;
		last = probe(use_blank);
		hit  = 1'b0;
		n    = 0;
		while (!timed_out && !hit && n <= limit) begin
			@(negedge clk);
			n    = n + 1;
			hit  = (last != level) && (probe(use_blank) == level);
			last = probe(use_blank);
		end
		if (!timed_out && !hit) begin
			timed_out    = 1'b1;
			other_errors = other_errors + 1;
			$display("Timed out waiting for the %s", what);
		end
	endtask

	initial begin
		clk          = 1'b0;
		arst_n       = 1'b1;
		loader_we    = 1'b0;
		loader_addr  = '0;
		loader_data  = '0;
		seed         = 27;
		other_errors = 0;
		timed_out    = 1'b0;
		// RAM has no reset, first image goes in ahead of it
		load_image();
		arst_n = 1'b0;
		repeat (16) @(negedge clk);
		arst_n = 1'b1;
		// Frames one and two start
		wait_change(1'b0, 1'b0, 2 * frame_len, "first vertical sync");
		wait_change(1'b0, 1'b0, 2 * frame_len, "second vertical sync");
		// Fetch of frame two is complete by the end of visible line 6
		repeat (v_active - 1) begin
			wait_change(1'b1, 1'b0, frame_len, "end of a visible line");
		end
		load_image();
		// Frames three and four, then the sync that closes frame four
		repeat (3) begin
			wait_change(1'b0, 1'b0, 2 * frame_len, "next vertical sync");
		end
		wait_change(1'b0, 1'b1, 2 * frame_len, "end of the last vertical sync");
		// Checker samples that edge one clock later
		repeat (2) @(negedge clk);
		if (frames_checked != frames_run) begin
			other_errors = other_errors + 1;
			$display("Only %0d of %0d frames were checked", frames_checked, frames_run);
		end
		print_counts();
		if (sync_errors + pixel_errors + state_errors + other_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
hdl/display_pkg.sv
hdl/fb_ram.sv
hdl/scan_timing.sv
hdl/fb_fetch.sv
hdl/pixel_unpack.sv
hdl/display_top.sv
tb/display_checks.sv
tb/display_tb.sv
